// File: include/backend_consts.svh
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// data path and architectural register file.
`define XLEN 32
`define ARCH_REGS 32

// physical registers and their index width.
`define PHYS_REGS 48
`define PREG_W 6

// free list holds the physical registers that are not mapped at reset.
`define FREE_DEPTH 16
`define FREE_W 4

`define ROB_DEPTH 16
`define ROB_W 4

`define IQ_DEPTH 8
`define IQ_W 3

`endif

// File: hw/BackendPkg.sv
`default_nettype none
`include "backend_consts.svh"

package BackendPkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } RType;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } IType;

    // one fetched word, seen through either format.
    typedef union packed {
        RType r;
        IType i;
    } InstWord;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR
    } AluOp;

    typedef struct packed {
        logic             valid;
        logic             illegal;
        AluOp             aluOp;
        logic             useImm;
        logic [`XLEN-1:0] imm;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic             writesRd;
    } DecodedOp;

    // rd stays architectural because the ROB commits it.
    typedef struct packed {
        logic               valid;
        logic               illegal;
        AluOp               aluOp;
        logic               useImm;
        logic [`XLEN-1:0]   imm;
        logic [4:0]         rd;
        logic [`PREG_W-1:0] prs1;
        logic [`PREG_W-1:0] prs2;
        logic [`PREG_W-1:0] prd;
        logic [`PREG_W-1:0] oldPrd;
        logic [`ROB_W-1:0]  robIdx;
        logic               writesRd;
    } RenamedOp;

    typedef struct packed {
        AluOp               aluOp;
        logic               useImm;
        logic [`XLEN-1:0]   imm;
        logic [`PREG_W-1:0] prs1;
        logic [`PREG_W-1:0] prs2;
        logic [`PREG_W-1:0] prd;
        logic [`ROB_W-1:0]  robIdx;
        logic               writesRd;
    } IssueBundle;

    typedef struct packed {
        logic               en;
        logic               writesRd;
        logic [`PREG_W-1:0] prd;
        logic [`ROB_W-1:0]  robIdx;
        logic [`XLEN-1:0]   data;
    } WbBus;

    typedef struct packed {
        logic             en;
        logic             we;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } CommitBus;

    typedef struct packed {
        logic               en;
        logic [`PREG_W-1:0] prd;
    } FreeReq;

endpackage

`default_nettype wire

// File: hw/Decode.sv
`timescale 1ns/1ps
`default_nettype none

module Decode (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 fetchValid,
    input  BackendPkg::InstWord  fetchInst,
    input  logic                 stall,
    output BackendPkg::DecodedOp dec
);
    localparam logic [6:0] OpReg = 7'b0110011;
    localparam logic [6:0] OpImm = 7'b0010011;

    BackendPkg::DecodedOp decNext;

    always_comb begin
        decNext         = '0;
        decNext.valid   = fetchValid;
        decNext.rd      = fetchInst.r.rd;
        decNext.illegal = 1'b1;
        case (fetchInst.r.opcode)
            OpReg: begin
                decNext.rs1     = fetchInst.r.rs1;
                decNext.rs2     = fetchInst.r.rs2;
                decNext.illegal = 1'b0;
                case ({fetchInst.r.funct7, fetchInst.r.funct3})
                    10'b0000000_000: decNext.aluOp = BackendPkg::ADD;
                    10'b0100000_000: decNext.aluOp = BackendPkg::SUB;
                    10'b0000000_100: decNext.aluOp = BackendPkg::XOR;
                    10'b0000000_110: decNext.aluOp = BackendPkg::OR;
                    10'b0000000_111: decNext.aluOp = BackendPkg::AND;
                    default:         decNext.illegal = 1'b1;
                endcase
            end
            OpImm: begin
                decNext.rs1     = fetchInst.i.rs1;
                decNext.useImm  = 1'b1;
                decNext.imm     = {{20{fetchInst.i.imm12[11]}}, fetchInst.i.imm12};
                decNext.illegal = 1'b0;
                case (fetchInst.i.funct3)
                    3'b000:  decNext.aluOp = BackendPkg::ADD;
                    3'b100:  decNext.aluOp = BackendPkg::XOR;
                    3'b110:  decNext.aluOp = BackendPkg::OR;
                    3'b111:  decNext.aluOp = BackendPkg::AND;
                    default: decNext.illegal = 1'b1;
                endcase
            end
            default: ;
        endcase
        decNext.writesRd = !decNext.illegal; // rd 0 is filtered at rename.
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dec <= '0;
        end else if (!stall) begin
            dec <= decNext;
        end
    end
endmodule

`default_nettype wire

// File: hw/Rename.sv
`timescale 1ns/1ps
`default_nettype none
`include "backend_consts.svh"

module Rename (
    input  logic                 clk,
    input  logic                 rstN,
    input  BackendPkg::DecodedOp dec,
    input  logic                 stall,
    input  logic [`ROB_W-1:0]    robTail,
    input  BackendPkg::FreeReq   freePrd,
    output BackendPkg::RenamedOp renamed,
    output logic                 freeLow
);
    logic [`PREG_W-1:0] mapTable [`ARCH_REGS];
    logic [`PREG_W-1:0] freeList [`FREE_DEPTH];
    logic [`FREE_W-1:0] freeHead;
    logic [`FREE_W-1:0] freeTail;
    logic [`FREE_W:0]   freeCount;
    logic               fire;
    logic               alloc;

    assign fire    = dec.valid && !stall;
    assign alloc   = fire && dec.writesRd && (dec.rd != 5'd0);
    assign freeLow = freeCount < 2;

    // speculative map, updated as soon as a destination is renamed.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                mapTable[i] <= `PREG_W'(i);
            end
        end else if (alloc) begin
            mapTable[dec.rd] <= freeList[freeHead];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `FREE_DEPTH; i++) begin
                freeList[i] <= `PREG_W'(`ARCH_REGS + i);
            end
            freeHead  <= '0;
            freeTail  <= '0;
            freeCount <= `FREE_DEPTH;
        end else begin
            if (alloc) begin
                freeHead <= freeHead + 1;
            end
            if (freePrd.en) begin
                freeList[freeTail] <= freePrd.prd; // returned by commit.
                freeTail           <= freeTail + 1;
            end
            freeCount <= freeCount + (`FREE_W+1)'(freePrd.en) - (`FREE_W+1)'(alloc);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            renamed <= '0;
        end else begin
            renamed.valid    <= fire;
            renamed.illegal  <= dec.illegal;
            renamed.aluOp    <= dec.aluOp;
            renamed.useImm   <= dec.useImm;
            renamed.imm      <= dec.imm;
            renamed.rd       <= dec.rd;
            renamed.writesRd <= alloc;
            renamed.prs1     <= mapTable[dec.rs1];
            renamed.prs2     <= mapTable[dec.rs2];
            renamed.prd      <= alloc ? freeList[freeHead] : '0;
            renamed.oldPrd   <= mapTable[dec.rd];
            renamed.robIdx   <= robTail;
        end
    end
endmodule

`default_nettype wire

// File: hw/ROB.sv
`timescale 1ns/1ps
`default_nettype none
`include "backend_consts.svh"

module ROB (
    input  logic                 clk,
    input  logic                 rstN,
    input  BackendPkg::RenamedOp renamed,
    input  BackendPkg::WbBus     wb,
    output logic [`ROB_W-1:0]    robTail,
    output logic                 robLow,
    output BackendPkg::FreeReq   freePrd,
    output BackendPkg::CommitBus commit
);
    logic               done   [`ROB_DEPTH];
    logic [4:0]         rdArch [`ROB_DEPTH];
    logic               we     [`ROB_DEPTH];
    logic [`PREG_W-1:0] oldPrd [`ROB_DEPTH];
    logic [`XLEN-1:0]   data   [`ROB_DEPTH];
    logic [`ROB_W-1:0]  head;
    logic [`ROB_W-1:0]  tail;
    logic [`ROB_W:0]    count;
    logic               retire;

    assign retire = (count != 0) && done[head];
    assign robLow = count > (`ROB_DEPTH - 2);

    // the op leaving rename this cycle already owns the current tail slot.
    assign robTail = tail + `ROB_W'(renamed.valid);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                done[i] <= 1'b0;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (renamed.valid) begin
                done[tail] <= renamed.illegal; // illegal ops never execute.
                tail       <= tail + 1;
            end
            if (wb.en) begin
                done[wb.robIdx] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1;
            end
            count <= count + (`ROB_W+1)'(renamed.valid) - (`ROB_W+1)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (renamed.valid) begin
            rdArch[tail] <= renamed.rd;
            we[tail]     <= renamed.writesRd;
            oldPrd[tail] <= renamed.oldPrd;
        end
        if (wb.en) begin
            data[wb.robIdx] <= wb.data;
        end
    end

    // one retirement per cycle, strictly from the head.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            commit  <= '0;
            freePrd <= '0;
        end else begin
            commit.en   <= retire;
            commit.we   <= retire && we[head];
            commit.rd   <= rdArch[head];
            commit.data <= we[head] ? data[head] : '0;
            freePrd.en  <= retire && we[head];
            freePrd.prd <= oldPrd[head];
        end
    end
endmodule

`default_nettype wire

// File: hw/IntIssueQueue.sv
`timescale 1ns/1ps
`default_nettype none
`include "backend_consts.svh"

module IntIssueQueue (
    input  logic                   clk,
    input  logic                   rstN,
    input  BackendPkg::RenamedOp   renamed,
    input  BackendPkg::WbBus       wb,
    output logic                   issueValid,
    output BackendPkg::IssueBundle issue,
    output logic                   iqLow
);
    BackendPkg::IssueBundle entry [`IQ_DEPTH];
    BackendPkg::IssueBundle enqOp;
    logic                   valid [`IQ_DEPTH];
    logic                   rdy1  [`IQ_DEPTH];
    logic                   rdy2  [`IQ_DEPTH];
    logic [`IQ_W-1:0]       age   [`IQ_DEPTH]; // number of older valid entries.
    logic [`PHYS_REGS-1:0]  busy;
    logic [`IQ_W:0]         used;
    logic [`IQ_W-1:0]       selIdx;
    logic [`IQ_W-1:0]       selAge;
    logic [`IQ_W-1:0]       freeIdx;
    logic                   wakeValid;
    logic                   enq;
    logic                   src1Ready;
    logic                   src2Ready;

    assign wakeValid = wb.en && wb.writesRd;
    assign enq       = renamed.valid && !renamed.illegal;
    assign iqLow     = used > (`IQ_DEPTH - 2);

    // a wakeup in the dispatch cycle must not be missed by the new entry.
    assign src1Ready = (renamed.prs1 == '0) || !busy[renamed.prs1] ||
                       (wakeValid && wb.prd == renamed.prs1);
    assign src2Ready = renamed.useImm || (renamed.prs2 == '0) || !busy[renamed.prs2] ||
                       (wakeValid && wb.prd == renamed.prs2);

    always_comb begin
        enqOp.aluOp    = renamed.aluOp;
        enqOp.useImm   = renamed.useImm;
        enqOp.imm      = renamed.imm;
        enqOp.prs1     = renamed.prs1;
        enqOp.prs2     = renamed.prs2;
        enqOp.prd      = renamed.prd;
        enqOp.robIdx   = renamed.robIdx;
        enqOp.writesRd = renamed.writesRd;
    end

    always_comb begin
        used       = '0;
        issueValid = 1'b0;
        selIdx     = '0;
        selAge     = '0;
        freeIdx    = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) freeIdx = `IQ_W'(i);
        end
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            used = used + (`IQ_W+1)'(valid[i]);
            if (valid[i] && rdy1[i] && rdy2[i] && (!issueValid || age[i] < selAge)) begin
                issueValid = 1'b1;
                selIdx     = `IQ_W'(i);
                selAge     = age[i];
            end
        end
    end

    assign issue = entry[selIdx];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= '0;
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                valid[i] <= 1'b0;
                rdy1[i]  <= 1'b0;
                rdy2[i]  <= 1'b0;
                age[i]   <= '0;
            end
        end else begin
            if (enq && renamed.writesRd) busy[renamed.prd] <= 1'b1;
            if (wakeValid) busy[wb.prd] <= 1'b0;
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                if (wakeValid && valid[i] && entry[i].prs1 == wb.prd) rdy1[i] <= 1'b1;
                if (wakeValid && valid[i] && entry[i].prs2 == wb.prd) rdy2[i] <= 1'b1;
                if (issueValid && valid[i] && age[i] > selAge) age[i] <= age[i] - 1;
            end
            if (issueValid) valid[selIdx] <= 1'b0;
            if (enq) begin
                valid[freeIdx] <= 1'b1;
                rdy1[freeIdx]  <= src1Ready;
                rdy2[freeIdx]  <= src2Ready;
                age[freeIdx]   <= `IQ_W'(used - (`IQ_W+1)'(issueValid));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq) entry[freeIdx] <= enqOp;
    end
endmodule

`default_nettype wire

// File: hw/Regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "backend_consts.svh"

module Regfile (
    input  logic               clk,
    input  logic               rstN,
    input  logic [`PREG_W-1:0] raddr1,
    input  logic [`PREG_W-1:0] raddr2,
    output logic [`XLEN-1:0]   rdata1,
    output logic [`XLEN-1:0]   rdata2,
    input  BackendPkg::WbBus   wb
);
    logic [`XLEN-1:0] regs [`PHYS_REGS];

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // all zeros at reset gives the initial architectural state.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.writesRd) begin
            regs[wb.prd] <= wb.data;
        end
    end
endmodule

`default_nettype wire

// File: hw/Execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "backend_consts.svh"

module Execute (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   issueValid,
    input  BackendPkg::IssueBundle issue,
    output logic [`PREG_W-1:0]     raddr1,
    output logic [`PREG_W-1:0]     raddr2,
    input  logic [`XLEN-1:0]       rdata1,
    input  logic [`XLEN-1:0]       rdata2,
    output BackendPkg::WbBus       wb
);
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] result;

    assign raddr1 = issue.prs1;
    assign raddr2 = issue.prs2;
    assign opB    = issue.useImm ? issue.imm : rdata2;

    always_comb begin
        case (issue.aluOp)
            BackendPkg::SUB: result = rdata1 - opB;
            BackendPkg::AND: result = rdata1 & opB;
            BackendPkg::OR:  result = rdata1 | opB;
            BackendPkg::XOR: result = rdata1 ^ opB;
            default:         result = rdata1 + opB;
        endcase
    end

    // registered result doubles as the wakeup for the issue queue.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wb <= '0;
        end else begin
            wb.en       <= issueValid;
            wb.writesRd <= issueValid && issue.writesRd;
            wb.prd      <= issue.prd;
            wb.robIdx   <= issue.robIdx;
            wb.data     <= result;
        end
    end
endmodule

`default_nettype wire

// File: hw/Backend.sv
`timescale 1ns/1ps
`default_nettype none
`include "backend_consts.svh"

module Backend (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 fetchValid,
    input  BackendPkg::InstWord  fetchInst,
    output logic                 stall,
    output BackendPkg::CommitBus commit
);
    BackendPkg::DecodedOp   dec;
    BackendPkg::RenamedOp   renamed;
    BackendPkg::IssueBundle issue;
    BackendPkg::WbBus       wb;
    BackendPkg::FreeReq     freePrd;
    logic [`ROB_W-1:0]      robTail;
    logic [`PREG_W-1:0]     raddr1;
    logic [`PREG_W-1:0]     raddr2;
    logic [`XLEN-1:0]       rdata1;
    logic [`XLEN-1:0]       rdata2;
    logic                   issueValid;
    logic                   freeLow;
    logic                   robLow;
    logic                   iqLow;

    // each low flag keeps a margin of two for the op between decode and dispatch.
    assign stall = freeLow | robLow | iqLow;

    Decode decode(.*);

    Rename rename(.*);

    ROB rob(.*);

    IntIssueQueue intIssueQueue(.*);

    Regfile regfile(.*);

    Execute execute(.*);
endmodule

`default_nettype wire

// File: verification/Backend_assert.sv
`timescale 1ns/1ps
`default_nettype none

module BackendAssert (
    input logic                 clk,
    input logic                 rstN,
    input logic                 stall,
    input BackendPkg::CommitBus commit
);
    // a reset edge clears the commit register and every occupancy count.
    noCommitInReset: assert property (@(posedge clk) !rstN |=> !commit.en)
        else $error("commit pulse seen while reset is applied");

    noStallInReset: assert property (@(posedge clk) !rstN |=> !stall)
        else $error("stall raised while reset is applied");

    noWriteToZero: assert property (@(posedge clk) disable iff (!rstN)
        commit.we |-> commit.rd != 5'd0)
        else $error("commit writes architectural register 0");
endmodule

`default_nettype wire

// File: verification/BackendTb.sv
`timescale 1ns/1ps
`default_nettype none

module BackendTb;
    localparam int ClkPeriod     = 10;
    localparam int FixedInsts    = 25;
    localparam int StreamLen     = 48;
    localparam int NumRandom     = 300;
    localparam int TotalInsts    = FixedInsts + StreamLen + NumRandom;
    localparam int CyclesPerInst = 40;

    logic                 clk;
    logic                 rstN;
    logic                 fetchValid;
    BackendPkg::InstWord  fetchInst;
    logic                 stall;
    BackendPkg::CommitBus commit;

    logic [31:0]          modelRegs [32];
    BackendPkg::CommitBus expectQ [$];
    BackendPkg::CommitBus expected;
    logic [31:0]          rngState;
    int                   acceptCount;
    int                   commitCount;
    logic                 sawStall;

    Backend i_Backend (
        .clk(clk),
        .rstN(rstN),
        .fetchValid(fetchValid),
        .fetchInst(fetchInst),
        .stall(stall),
        .commit(commit)
    );

    bind Backend BackendAssert backendAssert (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .commit(commit)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkEqual(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            abortRun($sformatf("error at %0d ns: %s is %h, expected %h", $time, name, got, want));
        end
    endtask

    function automatic logic [31:0] xorshift32();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] rInst(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iInst(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // executes one instruction in program order on the model register file.
    function automatic BackendPkg::CommitBus refExecute(input logic [31:0] inst);
        BackendPkg::CommitBus res;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          value;
        logic                 legal;
        logic [4:0]           rd;
        rd    = inst[11:7];
        a     = modelRegs[inst[19:15]];
        b     = modelRegs[inst[24:20]];
        legal = 1'b1;
        value = '0;
        if (inst[6:0] == 7'h33) begin
            case ({inst[31:25], inst[14:12]})
                {7'h00, 3'h0}: value = a + b;
                {7'h20, 3'h0}: value = a - b;
                {7'h00, 3'h4}: value = a ^ b;
                {7'h00, 3'h6}: value = a | b;
                {7'h00, 3'h7}: value = a & b;
                default:       legal = 1'b0;
            endcase
        end else if (inst[6:0] == 7'h13) begin
            b = {{20{inst[31]}}, inst[31:20]};
            case (inst[14:12])
                3'h0:    value = a + b;
                3'h4:    value = a ^ b;
                3'h6:    value = a | b;
                3'h7:    value = a & b;
                default: legal = 1'b0;
            endcase
        end else begin
            legal = 1'b0;
        end
        res.en   = 1'b1;
        res.we   = legal && (rd != 5'd0);
        res.rd   = rd;
        res.data = res.we ? value : '0;
        if (res.we) modelRegs[rd] = value;
        return res;
    endfunction

    // small register range so that random ops depend on each other often.
    function automatic logic [31:0] randInst();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] inst;
        r   = xorshift32();
        rd  = {2'b00, r[5:3]};
        rs1 = {2'b00, r[8:6]};
        rs2 = {2'b00, r[11:9]};
        case (r[26:25])
            2'd0:    f3 = 3'h0;
            2'd1:    f3 = 3'h4;
            2'd2:    f3 = 3'h6;
            default: f3 = 3'h7;
        endcase
        if (r[2:0] < 3'd4) begin
            case (r[26:24])
                3'd0:    inst = rInst(7'h00, 3'h0, rd, rs1, rs2);
                3'd1:    inst = rInst(7'h20, 3'h0, rd, rs1, rs2);
                3'd2:    inst = rInst(7'h00, 3'h7, rd, rs1, rs2);
                3'd3:    inst = rInst(7'h00, 3'h6, rd, rs1, rs2);
                3'd4:    inst = rInst(7'h00, 3'h4, rd, rs1, rs2);
                default: inst = rInst(7'h01, 3'h0, rd, rs1, rs2); // multiply decodes as illegal.
            endcase
        end else if (r[2:0] < 3'd7) begin
            inst = iInst(r[23:12], f3, rd, rs1);
        end else begin
            inst = r[31] ? {r[31:7], 7'b1100011} : iInst(r[23:12], 3'h1, rd, rs1);
        end
        return inst;
    endfunction

    // holds the word on the bus until a cycle without stall takes it.
    task automatic sendInst(input logic [31:0] inst);
        @(negedge clk);
        fetchValid = 1'b1;
        fetchInst  = inst;
        while (stall) begin
            sawStall = 1'b1;
            @(negedge clk);
        end
        expectQ.push_back(refExecute(inst));
        acceptCount++;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            fetchValid = 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (expectQ.size() != 0) @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (rstN && commit.en) begin
            if (expectQ.size() == 0) begin
                abortRun("a commit came out with no accepted instruction left to match it");
            end else begin
                expected = expectQ.pop_front();
                checkEqual("commit.we", 32'(commit.we), 32'(expected.we));
                checkEqual("commit.rd", 32'(commit.rd), 32'(expected.rd));
                checkEqual("commit.data", commit.data, expected.data);
                commitCount++;
            end
        end
    end

    initial begin
        #(TotalInsts * CyclesPerInst * ClkPeriod + 100 * ClkPeriod);
        abortRun($sformatf("timeout with %0d of %0d accepted instructions committed",
                           commitCount, acceptCount));
    end

    initial begin
        logic [31:0] r;
        clk         = 1'b0;
        rstN        = 1'b0;
        fetchValid  = 1'b0;
        fetchInst   = '0;
        rngState    = 32'd16;
        acceptCount = 0;
        commitCount = 0;
        sawStall    = 1'b0;
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkEqual("stall", 32'(stall), 32'd0);
        checkEqual("commit.en", 32'(commit.en), 32'd0);

        // independent ops from the all-zero state.
        sendInst(iInst(12'd5, 3'h0, 5'd1, 5'd0));
        sendInst(iInst(12'hffd, 3'h0, 5'd2, 5'd0));
        sendInst(iInst(12'h123, 3'h6, 5'd3, 5'd0));
        sendInst(iInst(12'h7ff, 3'h4, 5'd4, 5'd0));
        sendInst(rInst(7'h00, 3'h0, 5'd5, 5'd0, 5'd0));
        sendInst(rInst(7'h20, 3'h0, 5'd6, 5'd0, 5'd0));
        sendInst(rInst(7'h00, 3'h7, 5'd7, 5'd0, 5'd0));
        sendInst(iInst(12'h0ff, 3'h7, 5'd8, 5'd0));
        drain();

        sendInst(iInst(12'd10, 3'h0, 5'd9, 5'd1));
        sendInst(rInst(7'h00, 3'h0, 5'd10, 5'd9, 5'd2));
        sendInst(rInst(7'h20, 3'h0, 5'd11, 5'd10, 5'd3));
        sendInst(rInst(7'h00, 3'h4, 5'd12, 5'd11, 5'd4));
        sendInst(rInst(7'h00, 3'h6, 5'd13, 5'd12, 5'd9));
        sendInst(rInst(7'h00, 3'h7, 5'd14, 5'd13, 5'd11));
        sendInst(iInst(12'hfff, 3'h0, 5'd15, 5'd14));
        sendInst(rInst(7'h20, 3'h0, 5'd16, 5'd15, 5'd10));
        drain();

        sendInst(rInst(7'h00, 3'h0, 5'd0, 5'd1, 5'd2));
        sendInst(iInst(12'd1, 3'h0, 5'd0, 5'd1));
        sendInst(rInst(7'h00, 3'h0, 5'd17, 5'd0, 5'd1));
        sendInst(iInst(12'd0, 3'h0, 5'd18, 5'd0));
        drain();

        sendInst(32'h0000_0073);
        sendInst(32'hffff_ffff);
        sendInst(rInst(7'h01, 3'h0, 5'd1, 5'd1, 5'd2));
        sendInst(iInst(12'd3, 3'h1, 5'd1, 5'd1));
        sendInst(rInst(7'h00, 3'h0, 5'd19, 5'd1, 5'd2));
        drain();

        // a dependency chain issues every other cycle, so the queue fills up.
        sawStall = 1'b0;
        for (int k = 0; k < StreamLen; k++) begin
            sendInst(iInst(12'(k + 1), (k % 2 == 0) ? 3'h0 : 3'h4, 5'(20 + k % 4),
                           5'(20 + (k + 3) % 4)));
        end
        drain();
        if (!sawStall) abortRun("stall never rose during the back-to-back stream");

        for (int n = 0; n < NumRandom; n++) begin
            sendInst(randInst());
            r = xorshift32();
            if (r[1:0] == 2'b00) idle(1 + int'(r[2]));
        end
        drain();
        idle(10);

        $display("Everything OK");
        $finish;
    end
endmodule

`default_nettype wire

// File: sources.f
+incdir+include
hw/BackendPkg.sv
hw/Decode.sv
hw/Rename.sv
hw/ROB.sv
hw/IntIssueQueue.sv
hw/Regfile.sv
hw/Execute.sv
hw/Backend.sv
verification/Backend_assert.sv
verification/BackendTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module BackendTb -o simBackend

./obj_dir/simBackend > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log || ! grep -q "Everything OK" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
